/* verilog/tracker_config.svh */
// ======================================================================
// Build-time parameters of the request tracker
// Included by the package and by the modules that size logic from them
// ======================================================================
`ifndef TRACKER_CONFIG_SVH
`define TRACKER_CONFIG_SVH

// Number of tags in the heap, a power of two
`define TRACK_ENTRIES     16
// Payload widths
`define TRACK_ADDR_BITS   32
`define TRACK_META_BITS   16
`define TRACK_DATA_BITS   32
// Free slots that must stay ahead of the allocation pointer
`define TRACK_MIN_FREE    1
// Extra register stages on the heap read path
`define TRACK_RSP_STAGES  1

`endif

/* verilog/trackerPkg.sv */
// ======================================================================
// Shared types of the request tracker, used by RTL and testbench
// ======================================================================
`default_nettype none
`include "tracker_config.svh"

package trackerPkg;

    // Payload and index vectors
    typedef logic [$clog2(`TRACK_ENTRIES)-1:0]   tagIdx;
    typedef logic [$clog2(`TRACK_ENTRIES+1)-1:0] tagCount;
    typedef logic [`TRACK_ADDR_BITS-1:0]         reqAddr;
    typedef logic [`TRACK_META_BITS-1:0]         metaWord;
    typedef logic [`TRACK_DATA_BITS-1:0]         rspWord;
    typedef logic [1:0]                          cfgAddr;
    typedef logic [7:0]                          cfgWord;

    // FSM states
    typedef enum logic [2:0] {issueIdle, issueAlloc, issueMemWait, issueMemDrop, issueHostDrop}
        issueState;
    typedef enum logic [2:0] {cplIdle, cplLookup, cplHostWait, cplHostDrop, cplMemDrop}
        cplState;

endpackage

`default_nettype wire

/* verilog/tagHeap.sv */
// ======================================================================
// Tag heap handing out slots round robin and holding one metadata word
// per slot; data is written at allocation and read back by index with
// a fixed pipeline latency
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "tracker_config.svh"

module tagHeap
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   alloc,
    input  wire trackerPkg::metaWord allocData,
    output trackerPkg::tagIdx     allocIdx,
    output logic                  notFull,
    input  wire trackerPkg::tagIdx readIdx,
    output trackerPkg::metaWord   readData,
    input  wire                   free,
    input  wire trackerPkg::tagIdx freeIdx
);
    import trackerPkg::*;

    // notFull lags the busy bits by two cycles, so two more slots are required
    localparam int minFreeQ = `TRACK_MIN_FREE + 2;

    // One bit per slot, set while the slot is free
    logic [`TRACK_ENTRIES-1:0] notBusy;
    // Low bits repeated above the top to avoid wrap-around logic
    logic [minFreeQ+`TRACK_ENTRIES-1:0] notBusyRepl;
    logic [minFreeQ-1:0] checkBits;

    metaWord mem [`TRACK_ENTRIES];
    // Stage 0 is the memory read, the rest are output registers
    metaWord rdStage [`TRACK_RSP_STAGES+1];

    // ==================================================================
    // Allocation pointer and full check
    // ==================================================================
    assign notBusyRepl = {notBusy[minFreeQ-1:0], notBusy};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            allocIdx  <= '0;
            checkBits <= '0;
            notFull   <= 1'b0;
        end
        else
        begin
            // Window of slots starting at the pointer, then reduced
            checkBits <= notBusyRepl[allocIdx +: minFreeQ];
            notFull   <= &checkBits;
            if (alloc)
            begin
                allocIdx <= (allocIdx == tagIdx'(`TRACK_ENTRIES-1)) ? '0 : allocIdx + 1'b1;
            end
        end
    end

    // Busy bits, cleared on allocation, set again the cycle after a free
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            notBusy <= '1;
        end
        else
        begin
            if (alloc)
            begin
                notBusy[allocIdx] <= 1'b0;
            end
            if (free)
            begin
                notBusy[freeIdx] <= 1'b1;
            end
        end
    end

    // ==================================================================
    // Data memory and read pipeline
    // ==================================================================
    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            mem[allocIdx] <= allocData;
        end
        rdStage[0] <= mem[readIdx];
        for (int s = 1; s <= `TRACK_RSP_STAGES; s++)
        begin
            rdStage[s] <= rdStage[s-1];
        end
    end

    // Valid TRACK_RSP_STAGES+1 cycles after readIdx
    assign readData = rdStage[`TRACK_RSP_STAGES];

endmodule

`default_nettype wire

/* verilog/reqIssue.sv */
// ======================================================================
// Issue side of the tracker: accepts a host read request, allocates a
// tag and passes the address to memory, acking the host only once the
// memory handshake has completed
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module reqIssue
(
    input  wire                     clk,
    input  wire                     reset,
    // Host request handshake
    input  wire                     hostReq,
    input  wire trackerPkg::reqAddr hostAddr,
    input  wire trackerPkg::metaWord hostMeta,
    output logic                    hostAck,
    // Issue permission from the register block
    input  wire                     issueAllowed,
    // Heap allocation port
    input  wire                     heapNotFull,
    input  wire trackerPkg::tagIdx  heapAllocIdx,
    output logic                    heapAlloc,
    output trackerPkg::metaWord     heapAllocData,
    // Memory request handshake
    output logic                    memReq,
    input  wire                     memAck,
    output trackerPkg::reqAddr      memAddr,
    output trackerPkg::tagIdx       memTag
);
    import trackerPkg::*;

    issueState state;

    // Host holds its metadata stable while hostReq is up
    assign heapAllocData = hostMeta;
    // One allocation per pass through the Alloc state
    assign heapAlloc = (state == issueAlloc);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= issueIdle;
            memReq  <= 1'b0;
            hostAck <= 1'b0;
        end
        else
        begin
            case (state)
                issueIdle:
                begin
                    // hostAck is already low here
                    if (hostReq && issueAllowed && heapNotFull)
                    begin
                        state <= issueAlloc;
                    end
                end
                issueAlloc:
                begin
                    memReq <= 1'b1;
                    state  <= issueMemWait;
                end
                issueMemWait:
                begin
                    if (memAck)
                    begin
                        memReq <= 1'b0;
                        state  <= issueMemDrop;
                    end
                end
                issueMemDrop:
                begin
                    // Memory side finished, now answer the host
                    if (!memAck)
                    begin
                        hostAck <= 1'b1;
                        state   <= issueHostDrop;
                    end
                end
                issueHostDrop:
                begin
                    if (!hostReq)
                    begin
                        hostAck <= 1'b0;
                        state   <= issueIdle;
                    end
                end
                default:
                begin
                    state <= issueIdle;
                end
            endcase
        end
    end

    // Address and tag captured with the allocation
    always_ff @(posedge clk)
    begin
        if (state == issueAlloc)
        begin
            memAddr <= hostAddr;
            memTag  <= heapAllocIdx;
        end
    end

endmodule

`default_nettype wire

/* verilog/rspComplete.sv */
// ======================================================================
// Completion side of the tracker: takes a memory response, looks up
// the metadata stored under its tag, hands both to the host and frees
// the tag before acking memory
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "tracker_config.svh"

module rspComplete
(
    input  wire                      clk,
    input  wire                      reset,
    // Memory response handshake
    input  wire                      memRspReq,
    input  wire trackerPkg::tagIdx   memRspTag,
    input  wire trackerPkg::rspWord  memRspData,
    output logic                     memRspAck,
    // Heap read and free ports
    output trackerPkg::tagIdx        heapReadIdx,
    input  wire trackerPkg::metaWord heapReadData,
    output logic                     heapFree,
    output trackerPkg::tagIdx        heapFreeIdx,
    // Host completion handshake
    output logic                     cplReq,
    input  wire                      cplAck,
    output trackerPkg::metaWord      cplMeta,
    output trackerPkg::rspWord       cplData
);
    import trackerPkg::*;

    cplState state;
    // Counts the heap read latency
    logic [$clog2(`TRACK_RSP_STAGES+2)-1:0] waitCnt;
    tagIdx  rspTag;
    rspWord rspData;

    // Tag stays busy until freed, so the heap output holds during the handshake
    assign heapReadIdx = rspTag;
    assign heapFreeIdx = rspTag;
    assign cplMeta     = heapReadData;
    assign cplData     = rspData;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= cplIdle;
            waitCnt   <= '0;
            cplReq    <= 1'b0;
            memRspAck <= 1'b0;
            heapFree  <= 1'b0;
        end
        else
        begin
            heapFree <= 1'b0;
            case (state)
                cplIdle:
                begin
                    if (memRspReq)
                    begin
                        waitCnt <= '0;
                        state   <= cplLookup;
                    end
                end
                cplLookup:
                begin
                    // Raise cplReq as the read data lands
                    if (waitCnt == `TRACK_RSP_STAGES)
                    begin
                        cplReq <= 1'b1;
                        state  <= cplHostWait;
                    end
                    else
                    begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
                cplHostWait:
                begin
                    if (cplAck)
                    begin
                        cplReq <= 1'b0;
                        state  <= cplHostDrop;
                    end
                end
                cplHostDrop:
                begin
                    // Host done, release the tag and answer memory
                    if (!cplAck)
                    begin
                        heapFree  <= 1'b1;
                        memRspAck <= 1'b1;
                        state     <= cplMemDrop;
                    end
                end
                cplMemDrop:
                begin
                    if (!memRspReq)
                    begin
                        memRspAck <= 1'b0;
                        state     <= cplIdle;
                    end
                end
                default:
                begin
                    state <= cplIdle;
                end
            endcase
        end
    end

    // Response payload latched as the request is seen
    always_ff @(posedge clk)
    begin
        if (state == cplIdle && memRspReq)
        begin
            rspTag  <= memRspTag;
            rspData <= memRspData;
        end
    end

endmodule

`default_nettype wire

/* verilog/trackerRegs.sv */
// ======================================================================
// Configuration registers of the tracker: issue enable, outstanding
// limit and a read-only outstanding count; reads return a cycle late
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "tracker_config.svh"

module trackerRegs
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     cfgWrite,
    input  wire trackerPkg::cfgAddr cfgSel,
    input  wire trackerPkg::cfgWord cfgWrData,
    output trackerPkg::cfgWord      cfgRdData,
    input  wire                     allocPulse,
    input  wire                     freePulse,
    output logic                    issueAllowed
);
    import trackerPkg::*;

    logic    issueEnable;
    tagCount outLimit;
    tagCount outCount;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            issueEnable <= 1'b0;
            outLimit    <= tagCount'(`TRACK_ENTRIES);
            outCount    <= '0;
        end
        else
        begin
            if (cfgWrite && cfgSel == 2'd0)
            begin
                issueEnable <= cfgWrData[0];
            end
            if (cfgWrite && cfgSel == 2'd1)
            begin
                outLimit <= tagCount'(cfgWrData);
            end
            // Allocation and free in one cycle cancel out
            if (allocPulse && !freePulse)
            begin
                outCount <= outCount + 1'b1;
            end
            else if (freePulse && !allocPulse)
            begin
                outCount <= outCount - 1'b1;
            end
        end
    end

    // Registered read mux
    always_ff @(posedge clk)
    begin
        case (cfgSel)
            2'd0:    cfgRdData <= {7'b0, issueEnable};
            2'd1:    cfgRdData <= cfgWord'(outLimit);
            2'd2:    cfgRdData <= cfgWord'(outCount);
            default: cfgRdData <= '0;
        endcase
    end

    assign issueAllowed = issueEnable && (outCount < outLimit);

endmodule

`default_nettype wire

/* verilog/reqTracker.sv */
// ======================================================================
// Top level of the request tracker: register block, issue logic, tag
// heap and completion logic joined by the heap and counter signals
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module reqTracker
(
    input  wire                      clk,
    input  wire                      reset,
    // Host request
    input  wire                      hostReq,
    input  wire trackerPkg::reqAddr  hostAddr,
    input  wire trackerPkg::metaWord hostMeta,
    output logic                     hostAck,
    // Memory request
    output logic                     memReq,
    input  wire                      memAck,
    output trackerPkg::reqAddr       memAddr,
    output trackerPkg::tagIdx        memTag,
    // Memory response
    input  wire                      memRspReq,
    input  wire trackerPkg::tagIdx   memRspTag,
    input  wire trackerPkg::rspWord  memRspData,
    output logic                     memRspAck,
    // Host completion
    output logic                     cplReq,
    input  wire                      cplAck,
    output trackerPkg::metaWord      cplMeta,
    output trackerPkg::rspWord       cplData,
    // Configuration port
    input  wire                      cfgWrite,
    input  wire trackerPkg::cfgAddr  cfgSel,
    input  wire trackerPkg::cfgWord  cfgWrData,
    output trackerPkg::cfgWord       cfgRdData
);
    import trackerPkg::*;

    // Heap ports and issue permission
    logic    heapAlloc;
    metaWord heapAllocData;
    logic    heapNotFull;
    tagIdx   heapAllocIdx;
    tagIdx   heapReadIdx;
    metaWord heapReadData;
    logic    heapFree;
    tagIdx   heapFreeIdx;
    logic    issueAllowed;

    trackerRegs regsInst
    (
        .clk, .reset, .cfgWrite, .cfgSel, .cfgWrData, .cfgRdData,
        .allocPulse(heapAlloc), .freePulse(heapFree), .issueAllowed
    );

    reqIssue issueInst
    (
        .clk, .reset, .hostReq, .hostAddr, .hostMeta, .hostAck, .issueAllowed,
        .heapNotFull, .heapAllocIdx, .heapAlloc, .heapAllocData,
        .memReq, .memAck, .memAddr, .memTag
    );

    tagHeap heapInst
    (
        .clk, .reset, .alloc(heapAlloc), .allocData(heapAllocData),
        .allocIdx(heapAllocIdx), .notFull(heapNotFull),
        .readIdx(heapReadIdx), .readData(heapReadData),
        .free(heapFree), .freeIdx(heapFreeIdx)
    );

    rspComplete cplInst
    (
        .clk, .reset, .memRspReq, .memRspTag, .memRspData, .memRspAck,
        .heapReadIdx, .heapReadData, .heapFree, .heapFreeIdx,
        .cplReq, .cplAck, .cplMeta, .cplData
    );

endmodule

`default_nettype wire

/* testbench/reqTracker_assertions.sv */
// ======================================================================
// Concurrent checks on the tracker handshakes and the tag heap
// Bound into reqTracker; failures are counted for the testbench summary
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "tracker_config.svh"

module reqTracker_assertions
(
    input wire                      clk,
    input wire                      reset,
    input wire                      hostReq,
    input wire                      hostAck,
    input wire trackerPkg::reqAddr  hostAddr,
    input wire                      memReq,
    input wire                      memAck,
    input wire trackerPkg::reqAddr  memAddr,
    input wire trackerPkg::tagIdx   memTag,
    input wire                      memRspReq,
    input wire                      memRspAck,
    input wire trackerPkg::tagIdx   memRspTag,
    input wire                      cplReq,
    input wire                      cplAck,
    input wire trackerPkg::metaWord cplMeta,
    input wire trackerPkg::rspWord  cplData,
    input wire                      heapAlloc,
    input wire trackerPkg::tagIdx   heapAllocIdx,
    input wire [`TRACK_ENTRIES-1:0] heapNotBusy
);
    import trackerPkg::*;

    // Read by the testbench at the end of the run
    int failCount = 0;

    // ==================================================================
    // Ack only while the matching req is up
    // ==================================================================
    hostAckReq: assert property (@(posedge clk) disable iff (reset) $rose(hostAck) |-> hostReq)
        else begin failCount++; $error("hostAck rose without hostReq"); end
    memAckReq: assert property (@(posedge clk) disable iff (reset) $rose(memAck) |-> memReq)
        else begin failCount++; $error("memAck rose without memReq"); end
    rspAckReq: assert property (@(posedge clk) disable iff (reset) $rose(memRspAck) |-> memRspReq)
        else begin failCount++; $error("memRspAck rose without memRspReq"); end
    cplAckReq: assert property (@(posedge clk) disable iff (reset) $rose(cplAck) |-> cplReq)
        else begin failCount++; $error("cplAck rose without cplReq"); end

    // ==================================================================
    // Payload held while req is up
    // ==================================================================
    hostStable: assert property (@(posedge clk) disable iff (reset)
        hostReq && $past(hostReq) |-> $stable(hostAddr))
        else begin failCount++; $error("hostAddr changed during hostReq"); end
    memStable: assert property (@(posedge clk) disable iff (reset)
        memReq && $past(memReq) |-> $stable(memAddr) && $stable(memTag))
        else begin failCount++; $error("memAddr or memTag changed during memReq"); end
    rspStable: assert property (@(posedge clk) disable iff (reset)
        memRspReq && $past(memRspReq) |-> $stable(memRspTag))
        else begin failCount++; $error("memRspTag changed during memRspReq"); end
    cplStable: assert property (@(posedge clk) disable iff (reset)
        cplReq && $past(cplReq) |-> $stable(cplMeta) && $stable(cplData))
        else begin failCount++; $error("completion payload changed during cplReq"); end

    // Heap never hands out a slot that is still in use
    allocFree: assert property (@(posedge clk) disable iff (reset)
        heapAlloc |-> heapNotBusy[heapAllocIdx])
        else begin failCount++; $error("allocation into a busy heap slot"); end

endmodule

bind reqTracker reqTracker_assertions assertInst
(
    .clk, .reset, .hostReq, .hostAck, .hostAddr, .memReq, .memAck, .memAddr, .memTag,
    .memRspReq, .memRspAck, .memRspTag, .cplReq, .cplAck, .cplMeta, .cplData,
    .heapAlloc, .heapAllocIdx, .heapNotBusy(heapInst.notBusy)
);

`default_nettype wire

/* testbench/reqTracker_tb.sv */
// ======================================================================
// Testbench of the request tracker; host, memory and register traffic
// comes from the case file, with a memory model acking requests
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "tracker_config.svh"

module reqTracker_tb;
    import trackerPkg::*;

    // Rough upper bound of cycles for one case line
    localparam int cyclesPerCase = 400;

    logic    clk;
    logic    reset;
    logic    hostReq;
    reqAddr  hostAddr;
    metaWord hostMeta;
    logic    hostAck;
    logic    memReq;
    logic    memAck;
    reqAddr  memAddr;
    tagIdx   memTag;
    logic    memRspReq;
    tagIdx   memRspTag;
    rspWord  memRspData;
    logic    memRspAck;
    logic    cplReq;
    logic    cplAck;
    metaWord cplMeta;
    rspWord  cplData;
    logic    cfgWrite;
    cfgAddr  cfgSel;
    cfgWord  cfgWrData;
    cfgWord  cfgRdData;

    // Scoreboard state
    integer  seed = 32'h2d867ed4;
    int      errorCount = 0;
    int      checkCount = 0;
    string   testName = "setup";
    string   caseLines[$];
    logic    casesLoaded = 1'b0;
    // Next tag expected in round-robin order from 0
    tagIdx   tagPtr = '0;
    tagIdx   lastMemTag;
    reqAddr  lastMemAddr;
    reqAddr  addrOf [`TRACK_ENTRIES];
    metaWord metaOf [`TRACK_ENTRIES];

    reqTracker reqTracker_inst
    (
        .clk, .reset, .hostReq, .hostAddr, .hostMeta, .hostAck,
        .memReq, .memAck, .memAddr, .memTag,
        .memRspReq, .memRspTag, .memRspData, .memRspAck,
        .cplReq, .cplAck, .cplMeta, .cplData,
        .cfgWrite, .cfgSel, .cfgWrData, .cfgRdData
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==================================================================
    // Helpers
    // ==================================================================
    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual)
        begin
            errorCount++;
            $display("MISMATCH %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    function automatic int randomGap(input int maxGap);
        randomGap = $unsigned($random(seed)) % (maxGap + 1);
    endfunction

    function automatic tagIdx hexTag(input byte c);
        if (c >= "a")
            hexTag = tagIdx'(c - "a" + 10);
        else
            hexTag = tagIdx'(c - "0");
    endfunction

    task automatic writeReg(input cfgAddr sel, input cfgWord data);
        @(posedge clk);
        cfgWrite  <= 1'b1;
        cfgSel    <= sel;
        cfgWrData <= data;
        @(posedge clk);
        cfgWrite  <= 1'b0;
    endtask

    // Read data lands one cycle after the select
    task automatic readReg(input cfgAddr sel, input cfgWord expected);
        @(posedge clk);
        cfgSel <= sel;
        @(posedge clk);
        @(negedge clk);
        checkValue($sformatf("register %0d", sel), expected, cfgRdData);
    endtask

    task automatic raiseHost(input reqAddr addr, input metaWord meta);
        repeat (randomGap(3)) @(posedge clk);
        @(posedge clk);
        hostReq  <= 1'b1;
        hostAddr <= addr;
        hostMeta <= meta;
    endtask

    // Waits for hostAck and checks the tag and address seen by memory
    task automatic finishHost(input reqAddr addr, input metaWord meta);
        do @(posedge clk); while (!hostAck);
        checkValue($sformatf("memTag for %h", addr), tagPtr, lastMemTag);
        checkValue($sformatf("memAddr for %h", addr), addr, lastMemAddr);
        addrOf[tagPtr] = addr;
        metaOf[tagPtr] = meta;
        tagPtr = tagPtr + 1'b1;
        hostReq <= 1'b0;
        do @(posedge clk); while (hostAck);
    endtask

    // Host request that must not be issued within the window
    task automatic holdBlocked(input reqAddr addr, input metaWord meta, input int window);
        logic seen;
        seen = 1'b0;
        raiseHost(addr, meta);
        repeat (window)
        begin
            @(posedge clk);
            if (hostAck || memReq)
                seen = 1'b1;
        end
        checkValue("issue while blocked", 0, seen);
    endtask

    // One memory response and its host completion with cplAck held off for hold cycles
    task automatic respond(input tagIdx tag, input rspWord xorConst, input int hold);
        rspWord expData;
        logic   seen;
        expData = addrOf[tag] ^ xorConst;
        seen    = 1'b0;
        @(posedge clk);
        memRspReq  <= 1'b1;
        memRspTag  <= tag;
        memRspData <= expData;
        do @(posedge clk); while (!cplReq);
        checkValue($sformatf("cplMeta tag %0d", tag), metaOf[tag], cplMeta);
        checkValue($sformatf("cplData tag %0d", tag), expData, cplData);
        if (hold > 0)
        begin
            repeat (hold)
            begin
                @(posedge clk);
                if (memRspAck || !cplReq)
                    seen = 1'b1;
            end
            checkValue($sformatf("stall on tag %0d", tag), 0, seen);
        end
        repeat (randomGap(3)) @(posedge clk);
        cplAck <= 1'b1;
        do @(posedge clk); while (cplReq);
        cplAck <= 1'b0;
        do @(posedge clk); while (!memRspAck);
        memRspReq <= 1'b0;
        do @(posedge clk); while (memRspAck);
    endtask

    task automatic runCase(input string line);
        string       kind;
        string       tags;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        int          k;
        f1 = '0;
        f2 = '0;
        f3 = '0;
        f4 = '0;
        f5 = '0;
        void'($sscanf(line, "%s %h %h %h %h %h", kind, f1, f2, f3, f4, f5));
        case (kind)
            "W": writeReg(cfgAddr'(f1), cfgWord'(f2));
            "R": readReg(cfgAddr'(f1), cfgWord'(f2));
            "H":
            begin
                for (k = 0; k < f1; k++)
                begin
                    raiseHost(f2 + 4 * k, metaWord'(f3 + k));
                    finishHost(f2 + 4 * k, metaWord'(f3 + k));
                end
            end
            "S":
            begin
                // Blocked by the issue enable until it is set
                holdBlocked(f1, metaWord'(f2), f3);
                writeReg(2'd0, 8'd1);
                finishHost(f1, metaWord'(f2));
            end
            "L":
            begin
                // Blocked by the limit until one completion
                holdBlocked(f1, metaWord'(f2), f3);
                respond(tagIdx'(f4), f5, 0);
                finishHost(f1, metaWord'(f2));
            end
            "P":
            begin
                void'($sscanf(line, "%s %h %h %s", kind, f1, f2, tags));
                for (k = 0; k < tags.len(); k++)
                    respond(hexTag(tags.getc(k)), f1, f2);
            end
            default:
            begin
                errorCount++;
                $display("ERROR: %s has an unknown case kind", testName);
            end
        endcase
    endtask

    // ==================================================================
    // Memory request model
    // ==================================================================
    initial
    begin : memoryModel
        forever
        begin
            do @(posedge clk); while (memReq !== 1'b1);
            lastMemTag  = memTag;
            lastMemAddr = memAddr;
            repeat (randomGap(4)) @(posedge clk);
            memAck <= 1'b1;
            do @(posedge clk); while (memReq);
            memAck <= 1'b0;
        end
    end

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial
    begin : mainSequence
        int    fd;
        int    idx;
        string line;
        reset      = 1'b1;
        hostReq    = 1'b0;
        hostAddr   = '0;
        hostMeta   = '0;
        memAck     = 1'b0;
        memRspReq  = 1'b0;
        memRspTag  = '0;
        memRspData = '0;
        cplAck     = 1'b0;
        cfgWrite   = 1'b0;
        cfgSel     = '0;
        cfgWrData  = '0;
        fd = $fopen("testbench/reqTracker_cases.txt", "r");
        if (fd == 0)
        begin
            errorCount++;
            $display("ERROR: case file testbench/reqTracker_cases.txt could not be opened");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#")
                    caseLines.push_back(line);
            end
            $fclose(fd);
        end
        casesLoaded = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        for (idx = 0; idx < caseLines.size(); idx++)
        begin
            testName = $sformatf("case %0d", idx + 1);
            runCase(caseLines[idx]);
        end
        repeat (4) @(posedge clk);
        errorCount = errorCount + reqTracker_inst.assertInst.failCount;
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    // Limit scales with the number of case lines
    initial
    begin : watchdog
        wait (casesLoaded);
        repeat (caseLines.size() * cyclesPerCase + 1000) @(posedge clk);
        $display("ERROR: %s did not finish in time, a handshake is stuck", testName);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount + 1);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+verilog
verilog/trackerPkg.sv
verilog/tagHeap.sv
verilog/reqIssue.sv
verilog/rspComplete.sv
verilog/trackerRegs.sv
verilog/reqTracker.sv
testbench/reqTracker_assertions.sv
testbench/reqTracker_tb.sv

/* testbench/reqTracker_cases.txt */
# W sel data | R sel expect | H count addrBase metaBase | S addr meta window
# L addr meta window tag xor | P xor hold tags; all hex, one digit per tag in response order
R 0 0
R 1 10
R 2 0
S 00001000 a5a5 30
R 2 1
P 5a5a0000 0 0
H 6 00002000 0100
R 2 6
P 0000ffff 3 364152
R 2 0
W 1 4
R 1 4
H 4 00003000 0200
L 00004000 0300 30 9 12345678
R 2 4
P 11111111 0 a78b
W 1 10
H 7 00005000 0400
R 2 7
P cafef00d 8 20dfc1e
R 2 0
W 0 0
R 0 0
